/* list.f */
source/fpa_pkg.sv
source/fpa_bus_port.sv
source/fac_arbiter.sv
source/fac_regs.sv
source/fpa_sequencer.sv
source/fpa_top.sv
bench/fpa_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
# A $fatal in the simulation gives a nonzero exit status
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module fpa_tb -f list.f -o fpa_sim &&
./obj_dir/fpa_sim ||
exit 1

/* bench/fpa_tb.sv */
`timescale 1ns/1ps

module fpa_tb;

	localparam logic [23:0] BASE = 24'hFEA200;
	localparam int CLK_NS = 10;
	localparam int N_CONV = 20;
	localparam int N_ARITH = 6;
	// Commands issued over the whole run
	localparam int N_CMDS = 2 * N_CONV + 2 * 3 * N_ARITH + 6;
	// Worst case cycles per command with its operand loads and readback
	localparam int CMD_CYCLES = 250;

	logic        clk = 1'b0;
	logic        rst;
	logic        vda;
	logic        rw;
	logic [23:0] ad;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic        rdy;

	fpa_top #(
		.IO_BASE(BASE)
	) dut (
		.clk(clk),
		.rst(rst),
		.vda(vda),
		.rw(rw),
		.ad(ad),
		.din(din),
		.dout(dout),
		.rdy(rdy)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// ------------------------------------------------------------------------
	// Failure reporting and compare tasks
	// ------------------------------------------------------------------------

	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_fac(input string name, input fpa_pkg::fac_t got,
			input fpa_pkg::fac_t want);
		if (got !== want)
			fail_stop($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, want));
	endtask

	task automatic check_status(input string name, input fpa_pkg::fpa_status_t got,
			input fpa_pkg::fpa_status_t want);
		if (got !== want)
			fail_stop($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, want));
	endtask

	task automatic check_int(input string name, input logic signed [63:0] got,
			input logic signed [63:0] want);
		if (got !== want)
			fail_stop($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, want));
	endtask

	// Ends the run when the tests overrun their time budget
	initial
	begin
		#(N_CMDS * CMD_CYCLES * CLK_NS);
		fail_stop("Watchdog timeout: the tests did not finish in time");
	end

	// ------------------------------------------------------------------------
	// Reference rules
	// ------------------------------------------------------------------------

	function automatic fpa_pkg::fpa_status_t status_of(input logic busy, input logic ovf,
			input logic dropped);
		fpa_pkg::fpa_status_t s;
		s = '0;
		s.busy = busy;
		s.ovf = ovf;
		s.dropped = dropped;
		return s;
	endfunction

	// Integer placed in the top 64 mantissa bits and shifted up
	// until the two top bits differ
	function automatic fpa_pkg::fac_t to_float(input logic signed [63:0] x);
		fpa_pkg::fac_t f;
		f.exp = fpa_pkg::EXP_FIX;
		f.man = {x, 16'h0000};
		if (f.man == '0)
			f.exp = '0;
		while (f.man != '0 && f.man[79] == f.man[78] && f.exp != '0)
		begin
			f.man = f.man << 1;
			f.exp = f.exp - 16'd1;
		end
		return f;
	endfunction

	// Random nonzero integer with drop top bits of sign fill
	function automatic logic signed [63:0] rand_int(input int unsigned drop);
		logic signed [63:0] r;
		r = $signed({$urandom, $urandom});
		r = r >>> drop;
		if (r == 0)
			r = 64'sd7;
		return r;
	endfunction

	// ------------------------------------------------------------------------
	// Bus tasks start and end on a rising edge
	// ------------------------------------------------------------------------

	task automatic bus_write(input logic [7:0] off, input logic [7:0] data);
		vda <= 1'b1;
		rw <= 1'b0;
		ad <= {BASE[23:8], off};
		din <= data;
		@(posedge clk);
		// Idle cycle between accesses
		vda <= 1'b0;
		rw <= 1'b1;
		@(negedge clk);
		// Nothing selected so rdy stays high
		if (rdy !== 1'b1)
			fail_stop("rdy was low with no access selected");
		@(posedge clk);
	endtask

	task automatic bus_read(input logic [7:0] off, output logic [7:0] data);
		int waits;
		waits = 0;
		vda <= 1'b1;
		rw <= 1'b1;
		ad <= {BASE[23:8], off};
		@(negedge clk);
		if (rdy !== 1'b0)
			fail_stop("rdy was not low in the first cycle of a read");
		@(negedge clk);
		while (rdy !== 1'b1)
		begin
			waits++;
			if (waits > 4)
				fail_stop("rdy never returned high during a read");
			@(negedge clk);
		end
		data = dout;
		@(posedge clk);
		vda <= 1'b0;
		@(posedge clk);
	endtask

	// Operands go LSB first
	task automatic load_fac(input logic [7:0] off, input fpa_pkg::fac_t v);
		int i;
		for (i = 0; i < fpa_pkg::FAC_W / 8; i++)
			bus_write(off + 8'(i), v[8*i +: 8]);
	endtask

	task automatic read_fac(input logic [7:0] off, output fpa_pkg::fac_t v);
		logic [7:0]                b;
		logic [fpa_pkg::FAC_W-1:0] w;
		int                        i;
		for (i = 0; i < fpa_pkg::FAC_W / 8; i++)
		begin
			bus_read(off + 8'(i), b);
			w[8*i +: 8] = b;
		end
		v = fpa_pkg::fac_t'(w);
	endtask

	// Integer result sits in the upper 64 mantissa bits of FAC1
	task automatic read_int(output logic signed [63:0] v);
		fpa_pkg::fac_t f;
		read_fac(fpa_pkg::REG_FAC1, f);
		v = f.man[79:16];
	endtask

	task automatic wait_idle(output fpa_pkg::fpa_status_t st);
		logic [7:0] b;
		int         polls;
		polls = 0;
		bus_read(fpa_pkg::REG_CMD, b);
		st = fpa_pkg::fpa_status_t'(b);
		while (st.busy)
		begin
			polls++;
			if (polls >= 500)
				fail_stop("Command never finished: busy still set after 500 status reads");
			bus_read(fpa_pkg::REG_CMD, b);
			st = fpa_pkg::fpa_status_t'(b);
		end
	endtask

	task automatic run_cmd(input fpa_pkg::fpa_cmd_e c, output fpa_pkg::fpa_status_t st);
		bus_write(fpa_pkg::REG_CMD, 8'(c));
		wait_idle(st);
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------

	task automatic test_reset_state;
		logic [7:0]    b;
		fpa_pkg::fac_t v1;
		fpa_pkg::fac_t v2;
		fpa_pkg::fac_t r;
		bus_read(fpa_pkg::REG_CMD, b);
		check_status("status after reset", fpa_pkg::fpa_status_t'(b), status_of(0, 0, 0));
		read_fac(fpa_pkg::REG_FAC1, r);
		check_fac("fac1 after reset", r, '0);
		v1 = fpa_pkg::fac_t'({$urandom, $urandom, $urandom});
		v2 = fpa_pkg::fac_t'({$urandom, $urandom, $urandom});
		load_fac(fpa_pkg::REG_FAC1, v1);
		load_fac(fpa_pkg::REG_FAC2, v2);
		read_fac(fpa_pkg::REG_FAC1, r);
		check_fac("fac1 readback", r, v1);
		read_fac(fpa_pkg::REG_FAC2, r);
		check_fac("fac2 readback", r, v2);
	endtask

	// Fix-to-float and float-to-fix back to the same integer
	task automatic test_int_round_trip;
		logic signed [63:0]   x;
		logic signed [63:0]   got;
		fpa_pkg::fac_t        f;
		fpa_pkg::fpa_status_t st;
		int                   i;
		for (i = 0; i < N_CONV; i++)
		begin
			x = rand_int($urandom % 60);
			// Edge values first
			if (i == 0)
				x = -64'sd1;
			else if (i == 1)
				x = 64'sh8000_0000_0000_0000;
			else if (i == 2)
				x = 64'sh7FFF_FFFF_FFFF_FFFF;
			// Junk in the exponent and fraction bits must be ignored
			f.exp = 16'($urandom);
			f.man = {x, 16'($urandom)};
			load_fac(fpa_pkg::REG_FAC1, f);
			run_cmd(fpa_pkg::CMD_FIX2FLT, st);
			check_status("status after fix-to-float", st, status_of(0, 0, 0));
			read_fac(fpa_pkg::REG_FAC1, f);
			check_fac("fac1 after fix-to-float", f, to_float(x));
			run_cmd(fpa_pkg::CMD_FLT2FIX, st);
			check_status("status after float-to-fix", st, status_of(0, 0, 0));
			read_int(got);
			check_int("fac1 integer after float-to-fix", got, x);
		end
	endtask

	task automatic test_arith(input fpa_pkg::fpa_cmd_e op);
		logic signed [63:0]   a;
		logic signed [63:0]   b;
		logic signed [63:0]   want;
		logic signed [63:0]   got;
		fpa_pkg::fpa_status_t st;
		int unsigned          drop;
		int                   i;
		for (i = 0; i < N_ARITH; i++)
		begin
			// Operands small enough that products and sums fit in 64 bits
			drop = (op == fpa_pkg::CMD_MUL) ? 34 + $urandom % 20 : 3 + $urandom % 40;
			a = rand_int(drop);
			b = rand_int(drop);
			if (op == fpa_pkg::CMD_SUB && a < 0)
				a = -a;
			case (op)
			fpa_pkg::CMD_ADD:
				want = a + b;
			fpa_pkg::CMD_SUB:
				want = b - a;
			default:
				want = a * b;
			endcase
			load_fac(fpa_pkg::REG_FAC1, to_float(a));
			load_fac(fpa_pkg::REG_FAC2, to_float(b));
			run_cmd(op, st);
			check_status("status after arithmetic", st, status_of(0, 0, 0));
			run_cmd(fpa_pkg::CMD_FLT2FIX, st);
			check_status("status after float-to-fix", st, status_of(0, 0, 0));
			read_int(got);
			check_int("fac1 arithmetic result", got, want);
		end
	endtask

	// FAC2 write lands while a multiply runs
	task automatic test_dropped_write;
		logic signed [63:0]   a;
		logic signed [63:0]   b;
		logic signed [63:0]   got;
		fpa_pkg::fac_t        fb;
		fpa_pkg::fac_t        r;
		fpa_pkg::fpa_status_t st;
		a = rand_int(40);
		b = rand_int(40);
		fb = to_float(b);
		load_fac(fpa_pkg::REG_FAC1, to_float(a));
		load_fac(fpa_pkg::REG_FAC2, fb);
		bus_write(fpa_pkg::REG_CMD, 8'(fpa_pkg::CMD_MUL));
		bus_write(fpa_pkg::REG_FAC2, ~fb[7:0]);
		wait_idle(st);
		check_status("status after dropped write", st, status_of(0, 0, 1));
		read_fac(fpa_pkg::REG_FAC2, r);
		check_fac("fac2 after dropped write", r, fb);
		// Next command clears the flag
		run_cmd(fpa_pkg::CMD_FLT2FIX, st);
		check_status("status after next command", st, status_of(0, 0, 0));
		read_int(got);
		check_int("fac1 product", got, a * b);
	endtask

	task automatic test_overflow;
		fpa_pkg::fpa_status_t st;
		load_fac(fpa_pkg::REG_FAC1, '{exp: 16'hFFF0, man: 80'h4000_0000_0000_0000_0000});
		load_fac(fpa_pkg::REG_FAC2, '{exp: 16'hFFFA, man: 80'h6000_0000_0000_0000_0000});
		run_cmd(fpa_pkg::CMD_MUL, st);
		check_status("status after overflowing multiply", st, status_of(0, 1, 0));
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------

	initial
	begin
		void'($urandom(32'h1904));
		rst = 1'b1;
		vda = 1'b0;
		rw = 1'b1;
		ad = '0;
		din = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		test_reset_state;
		test_int_round_trip;
		test_arith(fpa_pkg::CMD_ADD);
		test_arith(fpa_pkg::CMD_SUB);
		test_arith(fpa_pkg::CMD_MUL);
		test_dropped_write;
		test_overflow;
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* source/fpa_top.sv */
`timescale 1ns/1ps

module fpa_top #(
	parameter logic [23:0] IO_BASE = 24'hFEA200
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        vda,
	input  logic        rw,
	input  logic [23:0] ad,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	output logic        rdy
);

	fpa_pkg::fac_wr_t     bus_wr;
	fpa_pkg::fac_wr_t     seq_wr;
	fpa_pkg::fac_wr_t     grant_wr;
	fpa_pkg::fac_t        fac1;
	fpa_pkg::fac_t        fac2;
	fpa_pkg::fpa_cmd_e    cmd;
	fpa_pkg::fpa_status_t status;
	logic                 cmd_strobe;
	logic                 busy;
	logic                 ovf;
	logic                 dropped;

	// Status byte, low bits read as zero
	assign status = '{busy: busy, ovf: ovf, dropped: dropped, zero: 5'b00000};

	// ------------------------------------------------------------------------
	// Processor side
	// ------------------------------------------------------------------------

	fpa_bus_port #(
		.IO_BASE(IO_BASE)
	) u_bus_port (
		.clk(clk),
		.rst(rst),
		.vda(vda),
		.rw(rw),
		.ad(ad),
		.din(din),
		.dout(dout),
		.rdy(rdy),
		.status(status),
		.fac1(fac1),
		.fac2(fac2),
		.bus_wr(bus_wr),
		.cmd_strobe(cmd_strobe),
		.cmd(cmd)
	);

	// ------------------------------------------------------------------------
	// Operand storage and arithmetic
	// ------------------------------------------------------------------------

	fac_arbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.seq_wr(seq_wr),
		.bus_wr(bus_wr),
		.busy(busy),
		.cmd_strobe(cmd_strobe),
		.grant_wr(grant_wr),
		.dropped(dropped)
	);

	fac_regs u_regs (
		.clk(clk),
		.rst(rst),
		.wr(grant_wr),
		.fac1(fac1),
		.fac2(fac2)
	);

	fpa_sequencer u_sequencer (
		.clk(clk),
		.rst(rst),
		.cmd_strobe(cmd_strobe),
		.cmd(cmd),
		.fac1(fac1),
		.fac2(fac2),
		.seq_wr(seq_wr),
		.busy(busy),
		.ovf(ovf)
	);

endmodule

/* source/fpa_sequencer.sv */
`timescale 1ns/1ps

module fpa_sequencer (
	input  logic               clk,
	input  logic               rst,
	input  logic               cmd_strobe,
	input  fpa_pkg::fpa_cmd_e  cmd,
	input  fpa_pkg::fac_t      fac1,
	input  fpa_pkg::fac_t      fac2,
	output fpa_pkg::fac_wr_t   seq_wr,
	output logic               busy,
	output logic               ovf
);

	localparam int MSB = fpa_pkg::MAN_W - 1;

	typedef enum logic [3:0] {
		S_IDLE,
		S_NEG,
		S_ALIGN,
		S_SUM,
		S_MUL_MAG,
		S_MUL_STEP,
		S_MUL_END,
		S_NORM,
		S_FIX,
		S_WRITE
	} state_e;

	state_e                     state;
	// Working copies of FAC1 and FAC2
	fpa_pkg::fac_t              a;
	fpa_pkg::fac_t              b;
	// Upper product half, a.man holds the lower half while multiplying
	logic [MSB:0]               hi;
	logic [6:0]                 cnt;
	logic                       neg_res;
	logic [fpa_pkg::MAN_W:0]    sum;
	logic [fpa_pkg::MAN_W:0]    step;
	logic [fpa_pkg::EXP_W+1:0]  mul_exp;

	// One alignment step of x toward a larger exponent
	function automatic fpa_pkg::fac_t shift_toward(input fpa_pkg::fac_t x,
			input logic [fpa_pkg::EXP_W-1:0] target);
		fpa_pkg::fac_t r;
		// Everything would shift out, jump straight to sign fill
		if ((target - x.exp) >= fpa_pkg::EXP_W'(fpa_pkg::MAN_W))
		begin
			r.exp = target;
			r.man = {fpa_pkg::MAN_W{x.man[MSB]}};
		end
		else
		begin
			r.exp = x.exp + 1'b1;
			r.man = {x.man[MSB], x.man[MSB:1]};
		end
		return r;
	endfunction

	// Sign-extended sum for overflow detection
	assign sum = {a.man[MSB], a.man} + {b.man[MSB], b.man};
	// Shift-add step, multiplier bit is the LSB of a.man
	assign step = {1'b0, hi} + (a.man[0] ? {1'b0, b.man} : '0);
	// Product exponent, two guard bits catch under and overflow
	assign mul_exp = {2'b00, a.exp} + {2'b00, b.exp} - {2'b00, fpa_pkg::EXP_BIAS} + 18'd2;

	assign busy = (state != S_IDLE);

	// Result always lands in FAC1 as one word
	always_comb
	begin
		seq_wr = '0;
		seq_wr.valid = (state == S_WRITE);
		seq_wr.whole = 1'b1;
		seq_wr.sel = 1'b0;
		seq_wr.word = a;
	end

	// ------------------------------------------------------------------------
	// Command FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			ovf <= 1'b0;
		end
		else
		begin
			case (state)
			S_IDLE:
				if (cmd_strobe)
				begin
					a <= fac1;
					b <= fac2;
					ovf <= 1'b0;
					case (cmd)
					fpa_pkg::CMD_ADD:
						state <= S_ALIGN;
					fpa_pkg::CMD_SUB:
						state <= S_NEG;
					fpa_pkg::CMD_MUL:
						state <= S_MUL_MAG;
					fpa_pkg::CMD_FIX2FLT:
					begin
						// Integer in the top 64 bits, fraction bits cleared
						a.exp <= fpa_pkg::EXP_FIX;
						a.man <= {fac1.man[MSB:16], 16'h0000};
						state <= S_NORM;
					end
					fpa_pkg::CMD_FLT2FIX:
						state <= S_FIX;
					default:
						state <= S_IDLE;
					endcase
				end
			// Subtract is FAC2 plus minus FAC1
			S_NEG:
			begin
				a.man <= -a.man;
				state <= S_ALIGN;
			end
			// Shift the smaller operand right until exponents match
			S_ALIGN:
				if (a.exp < b.exp)
					a <= shift_toward(a, b.exp);
				else if (b.exp < a.exp)
					b <= shift_toward(b, a.exp);
				else
					state <= S_SUM;
			S_SUM:
				if (sum[fpa_pkg::MAN_W] != sum[MSB])
				begin
					// Carry into the sign, shift back and bump exponent
					if (a.exp == '1)
					begin
						ovf <= 1'b1;
						state <= S_IDLE;
					end
					else
					begin
						a.man <= sum[fpa_pkg::MAN_W:1];
						a.exp <= a.exp + 1'b1;
						state <= S_NORM;
					end
				end
				else
				begin
					a.man <= sum[MSB:0];
					state <= S_NORM;
				end
			// Sign, exponent and magnitudes
			S_MUL_MAG:
				if (mul_exp[fpa_pkg::EXP_W+1:fpa_pkg::EXP_W] != 2'b00)
				begin
					ovf <= 1'b1;
					state <= S_IDLE;
				end
				else
				begin
					a.exp <= mul_exp[fpa_pkg::EXP_W-1:0];
					neg_res <= a.man[MSB] ^ b.man[MSB];
					a.man <= a.man[MSB] ? -a.man : a.man;
					b.man <= b.man[MSB] ? -b.man : b.man;
					hi <= '0;
					cnt <= 7'(MSB);
					state <= S_MUL_STEP;
				end
			// 80 shift-add steps, product bits enter a.man from the top
			S_MUL_STEP:
			begin
				hi <= step[fpa_pkg::MAN_W:1];
				a.man <= {step[0], a.man[MSB:1]};
				cnt <= cnt - 1'b1;
				if (cnt == 7'd0)
					state <= S_MUL_END;
			end
			// Keep the upper product half and restore the sign
			S_MUL_END:
			begin
				a.man <= neg_res ? -hi : hi;
				state <= S_NORM;
			end
			S_NORM:
				if (a.man == '0)
				begin
					// Zero normalizes all the way down
					a.exp <= '0;
					state <= S_WRITE;
				end
				else if (a.man[MSB] != a.man[MSB-1] || a.exp == '0)
					state <= S_WRITE;
				else
				begin
					a.man <= {a.man[MSB-1:0], 1'b0};
					a.exp <= a.exp - 1'b1;
				end
			// Denormalize to the integer exponent
			S_FIX:
				if (a.exp == fpa_pkg::EXP_FIX)
					state <= S_WRITE;
				else if (a.exp > fpa_pkg::EXP_FIX)
				begin
					// Too big for 64 bits
					ovf <= 1'b1;
					state <= S_IDLE;
				end
				else
					a <= shift_toward(a, fpa_pkg::EXP_FIX);
			S_WRITE:
				state <= S_IDLE;
			default:
				state <= S_IDLE;
			endcase
		end
	end

endmodule

/* source/fac_regs.sv */
`timescale 1ns/1ps

module fac_regs (
	input  logic              clk,
	input  logic              rst,
	input  fpa_pkg::fac_wr_t  wr,
	output fpa_pkg::fac_t     fac1,
	output fpa_pkg::fac_t     fac2
);

	// Index 0 is FAC1, index 1 is FAC2
	logic [fpa_pkg::FAC_W-1:0] acc [2];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc[0] <= '0;
			acc[1] <= '0;
		end
		else if (wr.valid)
		begin
			// Result write from the sequencer
			if (wr.whole)
				acc[wr.sel] <= wr.word;
			// Byte lane from the processor
			else
				acc[wr.sel][{wr.lane, 3'b000} +: 8] <= wr.byte_data;
		end
	end

	// Both operands visible to the bus port and the sequencer
	assign fac1 = acc[0];
	assign fac2 = acc[1];

endmodule

/* source/fac_arbiter.sv */
`timescale 1ns/1ps

module fac_arbiter (
	input  logic              clk,
	input  logic              rst,
	input  fpa_pkg::fac_wr_t  seq_wr,
	input  fpa_pkg::fac_wr_t  bus_wr,
	input  logic              busy,
	input  logic              cmd_strobe,
	output fpa_pkg::fac_wr_t  grant_wr,
	output logic              dropped
);

	logic bus_lost;

	// Bus is locked out for the whole command, sequencer writes fall inside it
	assign bus_lost = bus_wr.valid && busy;

	// Sequencer first, bus only when idle
	always_comb
	begin
		if (seq_wr.valid)
			grant_wr = seq_wr;
		else if (bus_wr.valid && !busy)
			grant_wr = bus_wr;
		else
			grant_wr = '0;
	end

	// ------------------------------------------------------------------------
	// Sticky dropped-write flag
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			dropped <= 1'b0;
		else if (bus_lost)
			dropped <= 1'b1;
		// A new command starts with a clean flag
		else if (cmd_strobe)
			dropped <= 1'b0;
	end

endmodule

/* source/fpa_bus_port.sv */
`timescale 1ns/1ps

module fpa_bus_port #(
	parameter logic [23:0] IO_BASE = 24'hFEA200
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   vda,
	input  logic                   rw,
	input  logic [23:0]            ad,
	input  logic [7:0]             din,
	output logic [7:0]             dout,
	output logic                   rdy,
	input  fpa_pkg::fpa_status_t   status,
	input  fpa_pkg::fac_t          fac1,
	input  fpa_pkg::fac_t          fac2,
	output fpa_pkg::fac_wr_t       bus_wr,
	output logic                   cmd_strobe,
	output fpa_pkg::fpa_cmd_e      cmd
);

	logic                      cs;
	logic [3:0]                lane;
	logic                      in_fac1;
	logic                      in_fac2;
	logic                      cmd_hit;
	logic [fpa_pkg::FAC_W-1:0] rd_word;
	logic [7:0]                rd_byte;
	logic                      rd_wait;

	// ------------------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------------------

	// Chip select on the upper 16 address bits
	assign cs = vda && (ad[23:8] == IO_BASE[23:8]);
	assign lane = ad[3:0];

	// Operand windows are 12 bytes each
	assign in_fac1 = (ad[7:4] == fpa_pkg::REG_FAC1[7:4]) && (lane < 4'(fpa_pkg::FAC_W / 8));
	assign in_fac2 = (ad[7:4] == fpa_pkg::REG_FAC2[7:4]) && (lane < 4'(fpa_pkg::FAC_W / 8));
	assign cmd_hit = (ad[7:0] == fpa_pkg::REG_CMD);

	// Operand byte writes go straight to the arbiter
	always_comb
	begin
		bus_wr = '0;
		bus_wr.valid = cs && !rw && (in_fac1 || in_fac2);
		bus_wr.sel = in_fac2;
		bus_wr.whole = 1'b0;
		bus_wr.lane = lane;
		bus_wr.byte_data = din;
	end

	// ------------------------------------------------------------------------
	// Read data
	// ------------------------------------------------------------------------

	assign rd_word = in_fac2 ? fac2 : fac1;

	always_comb
	begin
		if (cmd_hit)
			rd_byte = status;
		else if (in_fac1 || in_fac2)
			rd_byte = rd_word[{lane, 3'b000} +: 8];
		else
			rd_byte = 8'h00;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dout <= 8'h00;
			rd_wait <= 1'b0;
			cmd_strobe <= 1'b0;
			cmd <= fpa_pkg::CMD_NONE;
		end
		else
		begin
			// Remembers a select in the previous cycle
			rd_wait <= cs;
			// One-cycle strobe after a command write
			cmd_strobe <= cs && !rw && cmd_hit;
			if (cs && !rw && cmd_hit)
				cmd <= fpa_pkg::fpa_cmd_e'(din);
			if (cs && rw)
				dout <= rd_byte;
		end
	end

	// Reads wait one cycle for the registered byte
	assign rdy = (cs && rw) ? rd_wait : 1'b1;

endmodule

/* source/fpa_pkg.sv */
package fpa_pkg;

	// ------------------------------------------------------------------------
	// Number format
	// ------------------------------------------------------------------------

	// Exponent and mantissa field widths
	localparam int EXP_W = 16;
	localparam int MAN_W = 80;
	localparam int FAC_W = EXP_W + MAN_W;

	// Exponent of 2^0
	localparam logic [EXP_W-1:0] EXP_BIAS = 16'h8000;
	// Exponent of an integer sitting in the upper 64 mantissa bits
	localparam logic [EXP_W-1:0] EXP_FIX = 16'h803E;

	// Register offsets in the I/O page, operands stored LSB first
	localparam logic [7:0] REG_FAC1 = 8'h00;
	localparam logic [7:0] REG_CMD  = 8'h0F;
	localparam logic [7:0] REG_FAC2 = 8'h10;

	// Operand, exponent on top as in the byte map
	typedef struct packed {
		logic [EXP_W-1:0] exp;
		logic [MAN_W-1:0] man;
	} fac_t;

	// Command codes, code 4 (divide) is not implemented
	typedef enum logic [7:0] {
		CMD_NONE    = 8'd0,
		CMD_ADD     = 8'd1,
		CMD_SUB     = 8'd2,
		CMD_MUL     = 8'd3,
		CMD_FIX2FLT = 8'd5,
		CMD_FLT2FIX = 8'd6
	} fpa_cmd_e;

	// Register file write request
	typedef struct packed {
		logic       valid;
		logic       sel;        // 0 selects FAC1, 1 selects FAC2
		logic       whole;      // whole word, else one byte lane
		logic [3:0] lane;
		logic [7:0] byte_data;
		fac_t       word;
	} fac_wr_t;

	// Status byte as read at REG_CMD
	typedef struct packed {
		logic       busy;
		logic       ovf;
		logic       dropped;
		logic [4:0] zero;
	} fpa_status_t;

endpackage
